/* all.f */
+incdir+rtl
+incdir+tests
rtl/mlpTypesPkg.sv
rtl/mlpControlPkg.sv
rtl/featureLoader.sv
rtl/hiddenNeuron.sv
rtl/outputStage.sv
rtl/mlpTop.sv
tests/mlpTb.sv

/* rtl/featureLoader.sv */
`timescale 1ns/1ps
`include "mlp_macros.svh"

module featureLoader
	import mlpTypesPkg::*, mlpControlPkg::*;
(
	input logic clk,
	input logic reset,
	input logic cmdStrobe,
	input loaderOp cmdOp,
	input featureIndex cmdIndex,
	input sampleWord cmdData,
	output logic vecStrobe,
	output featureVector features,
	output logic runRejected
);

	localparam logic [`MLP_FEATURES-1:0] allLoaded = '1;

	logic [`MLP_FEATURES-1:0] loadedMask;
	loaderState state;
	logic indexInRange;
	logic doClear;
	logic doLoad;
	logic doRun;

	// the fill state follows directly from the loaded marks.
	always_comb
	begin
		if (loadedMask == allLoaded)
			state = loaderFull;
		else if (loadedMask != '0)
			state = loaderPartial;
		else
			state = loaderEmpty;
	end

	// index 15 has no slot behind it and is dropped.
	assign indexInRange = (cmdIndex < featureIndex'(`MLP_FEATURES));

	always_comb
	begin
		doClear = 1'b0;
		doLoad = 1'b0;
		doRun = 1'b0;
		if (cmdStrobe)
		begin
			case (cmdOp)
				opClear:
					doClear = 1'b1;
				opLoad:
					doLoad = indexInRange;
				opRun:
					doRun = 1'b1;
				default:
					doRun = 1'b0;
			endcase
		end
	end

	// the slots drive the features port directly and keep their values across runs.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			features <= '0;
			loadedMask <= '0;
		end
		else if (doClear)
		begin
			features <= '0;
			loadedMask <= '0;
		end
		else if (doLoad)
		begin
			features[cmdIndex] <= cmdData;
			loadedMask[cmdIndex] <= 1'b1;
		end
	end

	// a run is either passed on to the neurons or refused, never both.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vecStrobe <= 1'b0;
			runRejected <= 1'b0;
		end
		else
		begin
			vecStrobe <= doRun && (state == loaderFull);
			runRejected <= doRun && (state != loaderFull);
		end
	end

endmodule

/* rtl/hiddenNeuron.sv */
`timescale 1ns/1ps
`include "mlp_macros.svh"

module hiddenNeuron
	import mlpTypesPkg::*;
#(
	parameter weightVector WEIGHTS = '0,
	parameter sampleWord BIAS = '0
)
(
	input logic clk,
	input logic reset,
	input logic vecStrobe,
	input featureVector features,
	output logic actStrobe,
	output sampleWord activation
);

	featureVector featReg;
	logic strobeIn;
	sampleWord products [`MLP_FEATURES];
	sampleWord sumNext;
	sampleWord sumReg;
	logic strobeSum;

	// stage one captures the vector so the loader may change its slots right away.
	always_ff @(posedge clk)
	begin
		featReg <= features;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			strobeIn <= 1'b0;
		else
			strobeIn <= vecStrobe;
	end

	// each product keeps only its low word, overflow wraps silently.
	for (genvar i = 0; i < `MLP_FEATURES; i++)
	begin : genProduct
		assign products[i] = featReg[i] * WEIGHTS[i];
	end

	// the sum starts from the bias and wraps modulo 2^16 at every step.
	always_comb
	begin
		sumNext = BIAS;
		for (int i = 0; i < `MLP_FEATURES; i++)
		begin
			sumNext = sumNext + products[i];
		end
	end

	// stage two holds the raw sum.
	always_ff @(posedge clk)
	begin
		sumReg <= sumNext;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			strobeSum <= 1'b0;
		else
			strobeSum <= strobeIn;
	end

	// stage three applies ReLU.
	// a set sign bit means the wrapped sum is negative and the neuron stays silent.
	always_ff @(posedge clk)
	begin
		if (sumReg[`MLP_WIDTH-1])
			activation <= '0;
		else
			activation <= sumReg;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			actStrobe <= 1'b0;
		else
			actStrobe <= strobeSum;
	end

endmodule

/* rtl/mlpControlPkg.sv */
package mlpControlPkg;

	// command opcodes seen by the feature loader.
	typedef enum logic [1:0]
	{
		opClear,
		opLoad,
		opRun
	} loaderOp;

	// fill state of the feature slots.
	typedef enum logic [1:0]
	{
		loaderEmpty,
		loaderPartial,
		loaderFull
	} loaderState;

	// slot address, wide enough for one out-of-range value.
	typedef logic [3:0] featureIndex;

endpackage

/* rtl/mlpTop.sv */
`timescale 1ns/1ps
`include "mlp_macros.svh"

module mlpTop
	import mlpTypesPkg::*, mlpControlPkg::*;
(
	input logic clk,
	input logic reset,
	input logic cmdStrobe,
	input loaderOp cmdOp,
	input featureIndex cmdIndex,
	input sampleWord cmdData,
	output logic resultValid,
	output sampleWord score,
	output logic classHit,
	output logic runRejected
);

	logic vecStrobe;
	featureVector features;
	logic actStrobeA;
	sampleWord activationA;
	sampleWord activationB;

	featureLoader loader
	(
		.clk(clk),
		.reset(reset),
		.cmdStrobe(cmdStrobe),
		.cmdOp(cmdOp),
		.cmdIndex(cmdIndex),
		.cmdData(cmdData),
		.vecStrobe(vecStrobe),
		.features(features),
		.runRejected(runRejected)
	);

	// both hidden neurons see the same vector in the same cycle.
	hiddenNeuron
	#(
		.WEIGHTS(`MLP_HIDDEN_A_WEIGHTS),
		.BIAS(`MLP_HIDDEN_A_BIAS)
	)
	neuronA
	(
		.clk(clk),
		.reset(reset),
		.vecStrobe(vecStrobe),
		.features(features),
		.actStrobe(actStrobeA),
		.activation(activationA)
	);

	// neuron B runs in lockstep with A, so its strobe carries nothing new.
	hiddenNeuron
	#(
		.WEIGHTS(`MLP_HIDDEN_B_WEIGHTS),
		.BIAS(`MLP_HIDDEN_B_BIAS)
	)
	neuronB
	(
		.clk(clk),
		.reset(reset),
		.vecStrobe(vecStrobe),
		.features(features),
		.actStrobe(),
		.activation(activationB)
	);

	outputStage outStage
	(
		.clk(clk),
		.reset(reset),
		.actStrobe(actStrobeA),
		.activationA(activationA),
		.activationB(activationB),
		.resultValid(resultValid),
		.score(score),
		.classHit(classHit)
	);

endmodule

/* rtl/mlpTypesPkg.sv */
`include "mlp_macros.svh"

package mlpTypesPkg;

	// one fixed-point sample, two's complement.
	typedef logic signed [`MLP_WIDTH-1:0] sampleWord;

	// all features of one sample, feature 0 in the lowest word.
	typedef sampleWord [`MLP_FEATURES-1:0] featureVector;

	// neuron weights use the same layout as the features they multiply.
	typedef sampleWord [`MLP_FEATURES-1:0] weightVector;

endpackage

/* rtl/mlp_macros.svh */
`ifndef MLP_MACROS_SVH
`define MLP_MACROS_SVH

// word width and feature count shared by every stage.
`define MLP_WIDTH 16
`define MLP_FEATURES 15

// feature 0 sits in the lowest slot, so the last entry below is weight 0.
`define MLP_HIDDEN_A_WEIGHTS { \
	16'h01F4, 16'h02FD, 16'hFDE6, 16'h003C, 16'hFFCC, \
	16'h01AF, 16'hFFE8, 16'h01FF, 16'h0023, 16'h0365, \
	16'h0230, 16'hFD4E, 16'hFCFC, 16'hFF6F, 16'h017D }

`define MLP_HIDDEN_B_WEIGHTS { \
	16'h0097, 16'hFCE1, 16'h0033, 16'h01D0, 16'hFF9B, \
	16'h0254, 16'hFEEA, 16'h0046, 16'h0188, 16'hFDC3, \
	16'hFF05, 16'h0321, 16'h00A7, 16'hFE90, 16'h0112 }

`define MLP_HIDDEN_A_BIAS 16'sh0090
`define MLP_HIDDEN_B_BIAS 16'shFF40

// the output neuron favours neuron A and penalises neuron B.
`define MLP_OUT_WEIGHT_A 16'sh0005
`define MLP_OUT_WEIGHT_B 16'shFFFD
`define MLP_OUT_BIAS 16'shFFF8

`endif

/* rtl/outputStage.sv */
`timescale 1ns/1ps
`include "mlp_macros.svh"

module outputStage
	import mlpTypesPkg::*;
(
	input logic clk,
	input logic reset,
	input logic actStrobe,
	input sampleWord activationA,
	input sampleWord activationB,
	output logic resultValid,
	output sampleWord score,
	output logic classHit
);

	localparam sampleWord weightA = `MLP_OUT_WEIGHT_A;
	localparam sampleWord weightB = `MLP_OUT_WEIGHT_B;
	localparam sampleWord outBias = `MLP_OUT_BIAS;

	sampleWord termA;
	sampleWord termB;
	sampleWord sumNext;
	sampleWord sumReg;
	logic strobeSum;
	logic positive;

	// truncated products and a wrapped sum, same arithmetic as the hidden layer.
	assign termA = activationA * weightA;
	assign termB = activationB * weightB;
	assign sumNext = termA + termB + outBias;

	always_ff @(posedge clk)
	begin
		sumReg <= sumNext;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			strobeSum <= 1'b0;
		else
			strobeSum <= actStrobe;
	end

	// zero counts as a miss, only a strictly positive score is a hit.
	assign positive = !sumReg[`MLP_WIDTH-1] && (sumReg != '0);

	// score and class only move when a new result arrives.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultValid <= 1'b0;
			score <= '0;
			classHit <= 1'b0;
		end
		else
		begin
			resultValid <= strobeSum;
			if (strobeSum)
			begin
				score <= sumReg;
				classHit <= positive;
			end
		end
	end

endmodule

/* tests/mlpModel.svh */
`ifndef MLP_MODEL_SVH
`define MLP_MODEL_SVH

// network constants come from the shared macro header.
localparam weightVector weightsA = `MLP_HIDDEN_A_WEIGHTS;
localparam weightVector weightsB = `MLP_HIDDEN_B_WEIGHTS;
localparam sampleWord biasA = `MLP_HIDDEN_A_BIAS;
localparam sampleWord biasB = `MLP_HIDDEN_B_BIAS;
localparam sampleWord outWeightA = `MLP_OUT_WEIGHT_A;
localparam sampleWord outWeightB = `MLP_OUT_WEIGHT_B;
localparam sampleWord outBias = `MLP_OUT_BIAS;

logic [31:0] lfsrState = 32'h04078044;
featureVector modelSlots = '0;
logic [`MLP_FEATURES-1:0] modelMarks = '0;

// pending results and rejections, each tagged with the cycle it is due in.
int expTag[$];
sampleWord expScore[$];
logic expHit[$];
int rejTag[$];

// taps 32, 22, 2 and 1, one shift per bit handed out.
function automatic logic [31:0] randomBits(input int count);
	logic [31:0] value;
	logic feedback;
	value = '0;
	for (int i = 0; i < count; i++)
	begin
		feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], feedback};
		value = {value[30:0], feedback};
	end
	return value;
endfunction

// the full product is formed first, then only its low word is kept.
function automatic sampleWord wrapProduct(input sampleWord a, input sampleWord b);
	logic signed [31:0] full;
	full = a * b;
	return full[15:0];
endfunction

function automatic sampleWord hiddenRaw(input featureVector vec, input weightVector weights,
	input sampleWord bias);
	sampleWord sum;
	sum = bias;
	for (int i = 0; i < `MLP_FEATURES; i++)
		sum = sum + wrapProduct(vec[i], weights[i]);
	return sum;
endfunction

function automatic sampleWord relu(input sampleWord value);
	return (value < 0) ? sampleWord'(0) : value;
endfunction

function automatic void scoreFor(input featureVector vec, output sampleWord result,
	output logic hit);
	sampleWord actA;
	sampleWord actB;
	actA = relu(hiddenRaw(vec, weightsA, biasA));
	actB = relu(hiddenRaw(vec, weightsB, biasB));
	result = wrapProduct(actA, outWeightA) + wrapProduct(actB, outWeightB) + outBias;
	hit = (result > 0);
endfunction

// mirrors the loader for a command driven in cycle now.
function automatic void applyCommand(input loaderOp op, input featureIndex index,
	input sampleWord data, input int now);
	sampleWord result;
	logic hit;
	case (op)
		opClear:
		begin
			modelSlots = '0;
			modelMarks = '0;
		end
		opLoad:
			if (index < `MLP_FEATURES)
			begin
				modelSlots[index] = data;
				modelMarks[index] = 1'b1;
			end
		default:
			if (&modelMarks)
			begin
				scoreFor(modelSlots, result, hit);
				expTag.push_back(now + 6);
				expScore.push_back(result);
				expHit.push_back(hit);
			end
			else
				rejTag.push_back(now + 1);
	endcase
endfunction

`endif

/* tests/mlpTb.sv */
`timescale 1ns/1ps
`include "mlp_macros.svh"

module mlpTb
	import mlpTypesPkg::*, mlpControlPkg::*;
();

	localparam int maxGap = 3;
	localparam int singleRuns = 8;
	localparam int burstRuns = 12;
	localparam int reluCases = 2;
	// each command may be followed by a gap, and each wait spans at most one pipeline pass.
	localparam int totalCommands = 41 + singleRuns * 17 + 15 + burstRuns * 2 + 2 + reluCases * 16;
	localparam int totalWaits = 4 + singleRuns + 2 + reluCases;
	localparam int budgetCycles = 5 + totalCommands * (maxGap + 1) + totalWaits * 8;

	logic clk;
	logic reset;
	logic cmdStrobe;
	loaderOp cmdOp;
	featureIndex cmdIndex;
	sampleWord cmdData;
	logic resultValid;
	sampleWord score;
	logic classHit;
	logic runRejected;
	int cycleCount = 0;
	sampleWord heldScore = '0;
	logic heldHit = 1'b0;
	string testName = "resetState";

	`include "mlpModel.svh"

	mlpTop dut
	(
		.clk(clk),
		.reset(reset),
		.cmdStrobe(cmdStrobe),
		.cmdOp(cmdOp),
		.cmdIndex(cmdIndex),
		.cmdData(cmdData),
		.resultValid(resultValid),
		.score(score),
		.classHit(classHit),
		.runRejected(runRejected)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	task automatic failRun(input string message);
		$display("%s", message);
		$display("Test failed");
		$fatal(1);
	endtask

	initial
	begin
		#((budgetCycles + 20) * 20);
		failRun($sformatf("watchdog expired in %s before the run finished", testName));
	end

	// outputs are sampled on the falling edge, half a cycle after they change.
	always @(negedge clk)
	begin
		logic resultDue;
		logic rejectDue;
		resultDue = (expTag.size() > 0) && (expTag[0] == cycleCount);
		rejectDue = (rejTag.size() > 0) && (rejTag[0] == cycleCount);
		assert (resultValid === resultDue)
		else failRun($sformatf("%s: resultValid was %b in cycle %0d but %b was expected",
			testName, resultValid, cycleCount, resultDue));
		assert (runRejected === rejectDue)
		else failRun($sformatf("%s: runRejected was %b in cycle %0d but %b was expected",
			testName, runRejected, cycleCount, rejectDue));
		if (rejectDue)
			void'(rejTag.pop_front());
		if (resultDue)
		begin
			assert (score === expScore[0])
			else failRun($sformatf("[ERROR] %s: score expected %h actual %h",
				testName, expScore[0], score));
			assert (classHit === expHit[0])
			else failRun($sformatf("[ERROR] %s: classHit expected %b actual %b",
				testName, expHit[0], classHit));
			heldScore = expScore[0];
			heldHit = expHit[0];
			void'(expTag.pop_front());
			void'(expScore.pop_front());
			void'(expHit.pop_front());
		end
		else
		begin
			// between results the last score and class stay on the outputs.
			assert (score === heldScore && classHit === heldHit)
			else failRun($sformatf("[ERROR] %s: score and classHit expected %h %b actual %h %b",
				testName, heldScore, heldHit, score, classHit));
		end
	end

	task automatic idleCycles(input int count);
		repeat (count) @(negedge clk);
	endtask

	task automatic issueCommand(input loaderOp op, input featureIndex index, input sampleWord data);
		cmdStrobe = 1'b1;
		cmdOp = op;
		cmdIndex = index;
		cmdData = data;
		applyCommand(op, index, data, cycleCount);
		@(negedge clk);
		cmdStrobe = 1'b0;
	endtask

	task automatic waitDrained();
		while (expTag.size() != 0 || rejTag.size() != 0)
			@(negedge clk);
	endtask

	function automatic featureVector randomVector();
		featureVector vec;
		for (int i = 0; i < `MLP_FEATURES; i++)
			vec[i] = sampleWord'(randomBits(16));
		return vec;
	endfunction

	function automatic featureIndex randomSlot();
		return featureIndex'(randomBits(4) % `MLP_FEATURES);
	endfunction

	// slots are written in a rotated order that starts at a random slot.
	task automatic loadSet(input featureVector vec, input bit withGaps);
		int first;
		int slot;
		first = randomBits(4) % `MLP_FEATURES;
		for (int i = 0; i < `MLP_FEATURES; i++)
		begin
			slot = (first + i) % `MLP_FEATURES;
			issueCommand(opLoad, featureIndex'(slot), vec[slot]);
			if (withGaps)
				idleCycles(randomBits(2));
		end
	endtask

	task automatic reluCase(input bit useB);
		featureVector vec;
		sampleWord raw;
		bit found;
		found = 1'b0;
		for (int t = 0; t < 64 && !found; t++)
		begin
			vec = randomVector();
			raw = useB ? hiddenRaw(vec, weightsB, biasB) : hiddenRaw(vec, weightsA, biasA);
			found = (raw < 0);
		end
		assert (found)
		else failRun("no feature vector with a negative hidden sum was found");
		loadSet(vec, 1'b0);
		issueCommand(opRun, '0, '0);
		waitDrained();
	endtask

	initial
	begin
		featureVector vec;
		cmdStrobe = 1'b0;
		cmdOp = opClear;
		cmdIndex = '0;
		cmdData = '0;
		reset = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		idleCycles(2);

		testName = "rejection";
		issueCommand(opRun, '0, '0);
		waitDrained();
		for (int i = 0; i < 5; i++)
			issueCommand(opLoad, featureIndex'(i), sampleWord'(randomBits(16)));
		issueCommand(opRun, '0, '0);
		waitDrained();
		loadSet(randomVector(), 1'b0);
		issueCommand(opClear, '0, '0);
		issueCommand(opRun, '0, '0);
		waitDrained();
		// index 15 has no slot, so the result that follows must ignore it.
		loadSet(randomVector(), 1'b0);
		issueCommand(opLoad, 4'd15, sampleWord'(randomBits(16)));
		issueCommand(opRun, '0, '0);
		waitDrained();

		testName = "singleEval";
		for (int r = 0; r < singleRuns; r++)
		begin
			issueCommand(opClear, '0, '0);
			idleCycles(randomBits(2));
			loadSet(randomVector(), 1'b1);
			issueCommand(opRun, '0, '0);
			waitDrained();
		end

		testName = "backToBack";
		loadSet(randomVector(), 1'b0);
		for (int r = 0; r < burstRuns; r++)
		begin
			issueCommand(opRun, '0, '0);
			if (randomBits(1))
				issueCommand(opLoad, randomSlot(), sampleWord'(randomBits(16)));
		end
		waitDrained();

		testName = "persistence";
		issueCommand(opLoad, randomSlot(), sampleWord'(randomBits(16)));
		issueCommand(opRun, '0, '0);
		waitDrained();

		testName = "reluClamp";
		reluCase(1'b0);
		reluCase(1'b1);

		idleCycles(8);
		if (expTag.size() == 0 && rejTag.size() == 0)
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
			failRun("results were still outstanding when the stimulus ended");
	end

endmodule
